// File: Bender.yml
package:
  name: mac_engine

sources:
  - include_dirs:
      - logic
    files:
      - logic/mac_pkg.sv
      - logic/mac_ctrl.sv
      - logic/mac_operand_mem.sv
      - logic/mac_muladd.sv
      - logic/mac_result_mem.sv
      - logic/mac_top.sv

  - target: simulation
    include_dirs:
      - logic
    files:
      - bench/mac_tb.sv

// File: bench/mac_tb.sv
`default_nettype none

`include "mac_macros.svh"

module mac_tb;

   // Roughly four cycles per bus access, plus the streams of five runs.
   localparam int access_cycles = 4;
   localparam int n_accesses = 8 + 4 * 256 + 5 * (4 + 16) + 2 * 16;
   localparam int run_cycles = 5 * (256 + 16);
   localparam int cycle_limit = 2 * (access_cycles * n_accesses + run_cycles);

   logic                   clk = 1'b0;
   logic                   rst;
   logic                   cyc;
   logic                   stb;
   logic                   we;
   logic [`MAC_ADR_W-1:0]  adr;
   logic [`MAC_WORD_W-1:0] dat_w;
   logic [`MAC_WORD_W-1:0] dat_r;
   logic                   ack;

   logic [31:0]            lcg_state = 32'he524_adda;
   logic [`MAC_DATA_W-1:0] opa [256];        // Model copy of bank A.
   logic [`MAC_DATA_W-1:0] opb [256];
   int                     cycles = 0;
   int                     checks = 0;
   int                     errors = 0;
   int                     errs_mark = 0;
   int                     tests = 0;
   int                     iters;
   int                     per;
   logic [5:0]             sh;
   mac_pkg::mac_op_e       op;
   logic [31:0]            word;
   logic [31:0]            rd;

   mac_top dut0 (
      .clk   (clk),
      .rst   (rst),
      .cyc   (cyc),
      .stb   (stb),
      .we    (we),
      .adr   (adr),
      .dat_w (dat_w),
      .dat_r (dat_r),
      .ack   (ack)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Errors found");
         $finish;
      end
   end

   // ==========================================================
   // Helpers
   // ==========================================================

   function automatic logic [31:0] rand_word();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic int rand_range(input int n);
      logic [31:0] w;
      w = rand_word();
      return int'(w[31:16]) % n;                   // Upper bits are less periodic.
   endfunction

   // Expected word for one iteration, in 32-bit two's complement.
   function automatic logic [`MAC_DATA_W-1:0] model_result(input int it, input int p,
                                                           input mac_pkg::mac_op_e o,
                                                           input logic [5:0] s);
      int acc;
      int a;
      int b;
      int idx;
      acc = 0;
      for (int j = 0; j < p; j++) begin
         idx = (it * p + j) % 256;
         a = $signed(opa[idx]);
         b = $signed(opb[idx]);
         if (j == 0)
            acc = a * b;                           // Period restart.
         else if (o == mac_pkg::MAC_OP_SUB)
            acc = acc - a * b;
         else
            acc = acc + a * b;
      end
      acc = acc >>> s;
      return acc[`MAC_DATA_W-1:0];
   endfunction

   task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Error at time %0t: %s, read %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic report_test(input string name);
      int n;
      n = errors - errs_mark;
      tests++;
      $display("Test %0d %s: %s (%0d errors)", tests, name, n == 0 ? "passed" : "failed", n);
      errs_mark = errors;
   endtask

   // ==========================================================
   // Bus tasks
   // ==========================================================

   task automatic wb_write(input logic [`MAC_ADR_W-1:0] a, input logic [31:0] d);
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we <= 1'b1;
      adr <= a;
      dat_w <= d;
      do @(negedge clk); while (!ack);
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we <= 1'b0;
   endtask

   task automatic wb_read(input logic [`MAC_ADR_W-1:0] a, output logic [31:0] d);
      @(posedge clk);
      cyc <= 1'b1;
      stb <= 1'b1;
      we <= 1'b0;
      adr <= a;
      do @(negedge clk); while (!ack);
      d = dat_r;                                   // Stable mid-cycle.
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
   endtask

   task automatic wait_done();
      logic [31:0] st;
      st = '0;
      while (!st[1])
         wb_read(`MAC_REG_CTRL, st);
   endtask

   task automatic start_job(input int it, input int p, input mac_pkg::mac_op_e o,
                            input logic [5:0] s);
      logic [`MAC_CNT_W-1:0] it_v;
      logic [`MAC_CNT_W-1:0] p_v;
      it_v = it[`MAC_CNT_W-1:0];
      p_v = p[`MAC_CNT_W-1:0];
      wb_write(`MAC_REG_LOOP, {{(32 - 2 * `MAC_CNT_W){1'b0}}, p_v, it_v});
      wb_write(`MAC_REG_UNIT, {{(32 - `MAC_SHIFT_W - 1){1'b0}}, s, o});
      wb_write(`MAC_REG_CTRL, 32'h1);
   endtask

   task automatic check_results(input int it, input int p, input mac_pkg::mac_op_e o,
                                input logic [5:0] s);
      logic [31:0] got;
      for (int i = 0; i < it; i++) begin
         wb_read(`MAC_BASE_RES + i[`MAC_ADR_W-1:0], got);
         check(got, {16'h0, model_result(i, p, o, s)}, $sformatf("result %0d", i));
      end
   endtask

   task automatic run_job(input int it, input int p, input mac_pkg::mac_op_e o,
                          input logic [5:0] s);
      start_job(it, p, o, s);
      wait_done();
      check_results(it, p, o, s);
   endtask

   // ==========================================================
   // Test sequence
   // ==========================================================

   initial begin
      rst = 1'b1;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      dat_w = '0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;

      wb_read(`MAC_REG_CTRL, rd);
      check(rd, 32'h0, "ctrl idle after reset");
      word = rand_word();
      wb_write(`MAC_REG_LOOP, word);
      wb_read(`MAC_REG_LOOP, rd);
      check(rd, word, "loop register readback");
      word = rand_word();
      wb_write(`MAC_REG_UNIT, word);
      wb_read(`MAC_REG_UNIT, rd);
      check(rd, word, "unit register readback");
      report_test("register readback");

      for (int i = 0; i < 256; i++) begin
         word = rand_word();
         opa[i] = word[15:0];
         opb[i] = word[31:16];
         wb_write(`MAC_BASE_OPA + i[`MAC_ADR_W-1:0], {16'h0, opa[i]});
         wb_write(`MAC_BASE_OPB + i[`MAC_ADR_W-1:0], {16'h0, opb[i]});
      end
      for (int i = 0; i < 256; i++) begin
         wb_read(`MAC_BASE_OPA + i[`MAC_ADR_W-1:0], rd);
         check(rd, {16'h0, opa[i]}, $sformatf("bank A word %0d", i));
         wb_read(`MAC_BASE_OPB + i[`MAC_ADR_W-1:0], rd);
         check(rd, {16'h0, opb[i]}, $sformatf("bank B word %0d", i));
      end
      report_test("operand memory readback");

      iters = 1 + rand_range(16);
      per = 1 + rand_range(256 / iters);
      run_job(iters, per, mac_pkg::MAC_OP_ADD, 6'd0);
      report_test("accumulation");

      iters = 2 + rand_range(15);                  // At least one restart.
      per = 1 + rand_range(256 / iters);
      run_job(iters, per, mac_pkg::MAC_OP_SUB, 6'd0);
      report_test("subtraction");

      iters = 1 + rand_range(16);
      per = 1 + rand_range(256 / iters);
      sh = 6'(rand_range(64));
      word = rand_word();
      op = mac_pkg::mac_op_e'(word[16]);
      run_job(iters, per, op, sh);
      report_test("shift");

      start_job(0, 5, mac_pkg::MAC_OP_ADD, 6'd0);
      wait_done();
      wb_read(`MAC_REG_CTRL, rd);
      check(rd, 32'h2, "ctrl done after zero-length run");
      for (int i = 0; i < iters; i++) begin
         wb_read(`MAC_BASE_RES + i[`MAC_ADR_W-1:0], rd);
         check(rd, {16'h0, model_result(i, per, op, sh)},
               $sformatf("result %0d after zero run", i));
      end
      start_job(8, 32, mac_pkg::MAC_OP_ADD, 6'd0);
      wb_read(`MAC_REG_CTRL, rd);
      check(rd, 32'h1, "ctrl busy during run");
      wb_write(`MAC_REG_CTRL, 32'h1);             // Must be ignored.
      wait_done();
      check_results(8, 32, mac_pkg::MAC_OP_ADD, 6'd0);
      report_test("zero length and busy start");

      $display("Tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/mac_ctrl.sv
`default_nettype none

`include "mac_macros.svh"

module mac_ctrl (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    cyc,
   input  logic                    stb,
   input  logic                    we,
   input  logic [`MAC_ADR_W-1:0]   adr,
   input  logic [`MAC_WORD_W-1:0]  dat_w,
   output logic [`MAC_WORD_W-1:0]  dat_r,
   output logic                    ack,
   output logic                    start,
   output logic [`MAC_CNT_W-1:0]   iterations,
   output logic [`MAC_CNT_W-1:0]   period,
   output mac_pkg::mac_op_e        opcode,
   output logic [`MAC_SHIFT_W-1:0] shift,
   output logic                    opnd_we,
   output logic                    opnd_bank,
   output logic [`MAC_OPND_AW-1:0] opnd_addr,
   output logic [`MAC_DATA_W-1:0]  opnd_wdata,
   output logic [`MAC_OPND_AW-1:0] opnd_raddr,
   input  logic [`MAC_DATA_W-1:0]  opnd_rdata,
   output logic [`MAC_RES_AW-1:0]  res_raddr,
   input  logic [`MAC_DATA_W-1:0]  res_rdata,
   input  logic                    out_valid
);

   localparam logic [1:0] st_idle = 2'd0;
   localparam logic [1:0] st_busy = 2'd1;
   localparam logic [1:0] st_done = 2'd2;
   localparam logic [`MAC_ADR_W-1:0] opnd_span = (1 << `MAC_OPND_AW) - 1;
   localparam logic [`MAC_ADR_W-1:0] res_span = (1 << `MAC_RES_AW) - 1;

   logic [1:0]             state;
   logic [`MAC_CNT_W-1:0]  res_cnt;
   mac_pkg::mac_cfg_u      loop_cfg;
   mac_pkg::mac_cfg_u      unit_cfg;
   logic                   req;
   logic                   wr;
   logic                   busy;
   logic                   done;
   logic                   hit_ctrl;
   logic                   hit_loop;
   logic                   hit_unit;
   logic                   hit_opa;
   logic                   hit_opb;
   logic                   hit_res;

   assign req = cyc && stb && !ack;          // New access, not yet acked.
   assign wr = req && we;

   assign hit_ctrl = adr == `MAC_REG_CTRL;
   assign hit_loop = adr == `MAC_REG_LOOP;
   assign hit_unit = adr == `MAC_REG_UNIT;
   assign hit_opa = (adr & ~opnd_span) == `MAC_BASE_OPA;
   assign hit_opb = (adr & ~opnd_span) == `MAC_BASE_OPB;
   assign hit_res = (adr & ~res_span) == `MAC_BASE_RES;

   assign busy = state == st_busy;
   assign done = state == st_done;

   assign iterations = loop_cfg.loop.iterations;
   assign period = loop_cfg.loop.period;
   assign opcode = unit_cfg.unit.opcode;
   assign shift = unit_cfg.unit.shift;

   // ==========================================================
   // Memory routing
   // ==========================================================

   assign opnd_we = wr && (hit_opa || hit_opb) && !busy;  // Dropped while running.
   assign opnd_bank = hit_opb;
   assign opnd_addr = adr[`MAC_OPND_AW-1:0];
   assign opnd_wdata = dat_w[`MAC_DATA_W-1:0];
   assign opnd_raddr = adr[`MAC_OPND_AW-1:0];
   assign res_raddr = adr[`MAC_RES_AW-1:0];

   always_comb begin
      dat_r = '0;
      if (ack) begin
         if (hit_ctrl)
            dat_r = {{(`MAC_WORD_W-2){1'b0}}, done, busy};
         else if (hit_loop)
            dat_r = loop_cfg.raw;
         else if (hit_unit)
            dat_r = unit_cfg.raw;
         else if (hit_opa || hit_opb)
            dat_r = {{(`MAC_WORD_W-`MAC_DATA_W){1'b0}}, opnd_rdata};
         else if (hit_res)
            dat_r = {{(`MAC_WORD_W-`MAC_DATA_W){1'b0}}, res_rdata};
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ack <= 1'b0;
         loop_cfg <= '0;
         unit_cfg <= '0;
      end else begin
         ack <= req;
         if (wr && hit_loop)
            loop_cfg.raw <= dat_w;
         if (wr && hit_unit)
            unit_cfg.raw <= dat_w;
      end
   end

   // ==========================================================
   // Run sequencer
   // ==========================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= st_idle;
         start <= 1'b0;
         res_cnt <= '0;
      end else begin
         start <= 1'b0;
         case (state)
            st_busy: begin
               if (out_valid)
                  res_cnt <= res_cnt + 1'b1;
               if (res_cnt == iterations || period == '0)
                  state <= st_done;                // Also ends zero-length runs.
            end
            default: begin
               if (wr && hit_ctrl && dat_w[0]) begin
                  start <= 1'b1;
                  state <= st_busy;
                  res_cnt <= '0;
               end
            end
         endcase
      end
   end

   a_ack_follows_req: assert property (@(posedge clk) disable iff (rst)
      ack |-> $past(cyc && stb))
      else $error("ack raised without a bus request");

endmodule

`default_nettype wire

// File: logic/mac_macros.svh
`ifndef MAC_MACROS_SVH
`define MAC_MACROS_SVH

// ==========================================================
// Datapath widths and depths
// ==========================================================

`define MAC_DATA_W  16                  // Operand width.
`define MAC_ACC_W   (2 * `MAC_DATA_W)   // Product and accumulator.
`define MAC_OPND_AW 8                   // 256 words per bank.
`define MAC_RES_AW  6                   // 64 result words.
`define MAC_CNT_W   10                  // Iteration and period counters.
`define MAC_SHIFT_W 6
`define MAC_WORD_W  32                  // Bus word.
`define MAC_ADR_W   12                  // Word address.

// ==========================================================
// Register map, word addresses
// ==========================================================

`define MAC_REG_CTRL 12'h000            // Wr bit 0 start, rd busy/done.
`define MAC_REG_LOOP 12'h001
`define MAC_REG_UNIT 12'h002
`define MAC_BASE_OPA 12'h100
`define MAC_BASE_OPB 12'h200
`define MAC_BASE_RES 12'h400

`endif

// File: logic/mac_muladd.sv
`default_nettype none

`include "mac_macros.svh"

module mac_muladd (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`MAC_DATA_W-1:0]  in0,
   input  logic [`MAC_DATA_W-1:0]  in1,
   input  logic                    in_valid,
   input  logic                    in_last_of_period,
   input  mac_pkg::mac_op_e        opcode,
   input  logic [`MAC_SHIFT_W-1:0] shift,
   output logic [`MAC_DATA_W-1:0]  out0,
   output logic                    out_valid
);

   logic signed [`MAC_DATA_W-1:0] a_q;
   logic signed [`MAC_DATA_W-1:0] b_q;
   logic signed [`MAC_ACC_W-1:0]  prod_q;
   logic signed [`MAC_ACC_W-1:0]  acc_q;
   logic signed [`MAC_ACC_W-1:0]  acc_shr;
   logic                          v1;
   logic                          l1;
   logic                          v2;
   logic                          l2;
   logic                          v3;
   logic                          l3;
   logic                          first;

   // ==========================================================
   // Datapath
   // ==========================================================

   assign acc_shr = acc_q >>> shift;

   always_ff @(posedge clk) begin
      a_q <= in0;                                  // Stage 1.
      b_q <= in1;
      prod_q <= a_q * b_q;                         // Stage 2.
      if (v2) begin
         if (first)
            acc_q <= prod_q;                       // Period restart.
         else if (opcode == mac_pkg::MAC_OP_SUB)
            acc_q <= acc_q - prod_q;
         else
            acc_q <= acc_q + prod_q;
      end
      if (v3 && l3)
         out0 <= acc_shr[`MAC_DATA_W-1:0];
   end

   // ==========================================================
   // Valid and period tracking
   // ==========================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         v1 <= 1'b0;
         l1 <= 1'b0;
         v2 <= 1'b0;
         l2 <= 1'b0;
         v3 <= 1'b0;
         l3 <= 1'b0;
         first <= 1'b1;
         out_valid <= 1'b0;
      end else begin
         v1 <= in_valid;
         l1 <= in_valid && in_last_of_period;
         v2 <= v1;
         l2 <= l1;
         v3 <= v2;
         l3 <= l2;
         if (v2)
            first <= l2;                           // Next pair opens a period.
         out_valid <= v3 && l3;
      end
   end

   a_out_after_last: assert property (@(posedge clk) disable iff (rst)
      out_valid |-> $past(in_valid && in_last_of_period, 4))
      else $error("result emitted without a period end four cycles earlier");

endmodule

`default_nettype wire

// File: logic/mac_operand_mem.sv
`default_nettype none

`include "mac_macros.svh"

module mac_operand_mem (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    opnd_we,
   input  logic                    opnd_bank,
   input  logic [`MAC_OPND_AW-1:0] opnd_addr,
   input  logic [`MAC_DATA_W-1:0]  opnd_wdata,
   input  logic [`MAC_OPND_AW-1:0] opnd_raddr,
   output logic [`MAC_DATA_W-1:0]  opnd_rdata,
   input  logic                    start,
   input  logic [`MAC_CNT_W-1:0]   iterations,
   input  logic [`MAC_CNT_W-1:0]   period,
   output logic [`MAC_DATA_W-1:0]  in0,
   output logic [`MAC_DATA_W-1:0]  in1,
   output logic                    in_valid,
   output logic                    in_last_of_period
);

   localparam int depth = 1 << `MAC_OPND_AW;

   logic [`MAC_DATA_W-1:0]  mem_a [depth];
   logic [`MAC_DATA_W-1:0]  mem_b [depth];
   logic [`MAC_DATA_W-1:0]  rd_a;
   logic [`MAC_DATA_W-1:0]  rd_b;
   logic                    bank_q;
   logic [`MAC_OPND_AW-1:0] raddr;
   logic [`MAC_OPND_AW-1:0] saddr;
   logic [`MAC_CNT_W-1:0]   pcnt;
   logic [`MAC_CNT_W-1:0]   icnt;
   logic                    active;
   logic                    period_end;

   // ==========================================================
   // Banks
   // ==========================================================

   assign raddr = active ? saddr : opnd_raddr;    // Stream owns the port.

   always_ff @(posedge clk) begin
      if (opnd_we) begin
         if (opnd_bank)
            mem_b[opnd_addr] <= opnd_wdata;
         else
            mem_a[opnd_addr] <= opnd_wdata;
      end
      rd_a <= mem_a[raddr];
      rd_b <= mem_b[raddr];
      bank_q <= opnd_bank;
   end

   assign opnd_rdata = bank_q ? rd_b : rd_a;
   assign in0 = rd_a;
   assign in1 = rd_b;

   // ==========================================================
   // Stream generator
   // ==========================================================

   assign period_end = pcnt == period - 1'b1;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active <= 1'b0;
         saddr <= '0;
         pcnt <= '0;
         icnt <= '0;
         in_valid <= 1'b0;
         in_last_of_period <= 1'b0;
      end else begin
         in_valid <= active;                       // Aligned with read data.
         in_last_of_period <= active && period_end;
         if (start) begin
            active <= (iterations != '0) && (period != '0);
            saddr <= '0;
            pcnt <= '0;
            icnt <= '0;
         end else if (active) begin
            saddr <= saddr + 1'b1;
            if (period_end) begin
               pcnt <= '0;
               if (icnt == iterations - 1'b1)
                  active <= 1'b0;                  // Last pair issued.
               else
                  icnt <= icnt + 1'b1;
            end else begin
               pcnt <= pcnt + 1'b1;
            end
         end
      end
   end

   a_no_write_in_stream: assert property (@(posedge clk) disable iff (rst)
      opnd_we |-> !active)
      else $error("operand write accepted during a stream");

endmodule

`default_nettype wire

// File: logic/mac_pkg.sv
`default_nettype none

`include "mac_macros.svh"

package mac_pkg;

   typedef enum logic {
      MAC_OP_ADD = 1'b0,                // Accumulate.
      MAC_OP_SUB = 1'b1                 // Subtract from first product.
   } mac_op_e;

   // One configuration word, seen as loop or unit setup.
   typedef union packed {
      logic [`MAC_WORD_W-1:0] raw;
      struct packed {
         logic [`MAC_WORD_W-2*`MAC_CNT_W-1:0] pad;
         logic [`MAC_CNT_W-1:0]               period;
         logic [`MAC_CNT_W-1:0]               iterations;
      } loop;
      struct packed {
         logic [`MAC_WORD_W-`MAC_SHIFT_W-2:0] pad;
         logic [`MAC_SHIFT_W-1:0]             shift;
         mac_op_e                             opcode;
      } unit;
   } mac_cfg_u;

endpackage

`default_nettype wire

// File: logic/mac_result_mem.sv
`default_nettype none

`include "mac_macros.svh"

module mac_result_mem (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   start,
   input  logic [`MAC_DATA_W-1:0] out0,
   input  logic                   out_valid,
   input  logic [`MAC_RES_AW-1:0] res_raddr,
   output logic [`MAC_DATA_W-1:0] res_rdata
);

   localparam int depth = 1 << `MAC_RES_AW;

   logic [`MAC_DATA_W-1:0] mem [depth];
   logic [`MAC_RES_AW-1:0] wr_idx;

   // ==========================================================
   // Write index
   // ==========================================================

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_idx <= '0;
      end else if (start) begin
         wr_idx <= '0;                             // New run, first slot.
      end else if (out_valid) begin
         wr_idx <= wr_idx + 1'b1;
      end
   end

   // ==========================================================
   // Storage
   // ==========================================================

   always_ff @(posedge clk) begin
      if (out_valid)
         mem[wr_idx] <= out0;
      res_rdata <= mem[res_raddr];                 // Host read.
   end

endmodule

`default_nettype wire

// File: logic/mac_top.sv
`default_nettype none

`include "mac_macros.svh"

module mac_top (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   cyc,
   input  logic                   stb,
   input  logic                   we,
   input  logic [`MAC_ADR_W-1:0]  adr,
   input  logic [`MAC_WORD_W-1:0] dat_w,
   output logic [`MAC_WORD_W-1:0] dat_r,
   output logic                   ack
);

   logic                    start;
   logic [`MAC_CNT_W-1:0]   iterations;
   logic [`MAC_CNT_W-1:0]   period;
   mac_pkg::mac_op_e        opcode;
   logic [`MAC_SHIFT_W-1:0] shift;
   logic                    opnd_we;
   logic                    opnd_bank;
   logic [`MAC_OPND_AW-1:0] opnd_addr;
   logic [`MAC_DATA_W-1:0]  opnd_wdata;
   logic [`MAC_OPND_AW-1:0] opnd_raddr;
   logic [`MAC_DATA_W-1:0]  opnd_rdata;
   logic [`MAC_RES_AW-1:0]  res_raddr;
   logic [`MAC_DATA_W-1:0]  res_rdata;
   logic [`MAC_DATA_W-1:0]  in0;
   logic [`MAC_DATA_W-1:0]  in1;
   logic                    in_valid;
   logic                    in_last_of_period;
   logic [`MAC_DATA_W-1:0]  out0;
   logic                    out_valid;

   mac_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .cyc        (cyc),
      .stb        (stb),
      .we         (we),
      .adr        (adr),
      .dat_w      (dat_w),
      .dat_r      (dat_r),
      .ack        (ack),
      .start      (start),
      .iterations (iterations),
      .period     (period),
      .opcode     (opcode),
      .shift      (shift),
      .opnd_we    (opnd_we),
      .opnd_bank  (opnd_bank),
      .opnd_addr  (opnd_addr),
      .opnd_wdata (opnd_wdata),
      .opnd_raddr (opnd_raddr),
      .opnd_rdata (opnd_rdata),
      .res_raddr  (res_raddr),
      .res_rdata  (res_rdata),
      .out_valid  (out_valid)
   );

   mac_operand_mem u_operand_mem (
      .clk               (clk),
      .rst               (rst),
      .opnd_we           (opnd_we),
      .opnd_bank         (opnd_bank),
      .opnd_addr         (opnd_addr),
      .opnd_wdata        (opnd_wdata),
      .opnd_raddr        (opnd_raddr),
      .opnd_rdata        (opnd_rdata),
      .start             (start),
      .iterations        (iterations),
      .period            (period),
      .in0               (in0),
      .in1               (in1),
      .in_valid          (in_valid),
      .in_last_of_period (in_last_of_period)
   );

   mac_muladd u_muladd (
      .clk               (clk),
      .rst               (rst),
      .in0               (in0),
      .in1               (in1),
      .in_valid          (in_valid),
      .in_last_of_period (in_last_of_period),
      .opcode            (opcode),
      .shift             (shift),
      .out0              (out0),
      .out_valid         (out_valid)
   );

   mac_result_mem u_result_mem (
      .clk       (clk),
      .rst       (rst),
      .start     (start),
      .out0      (out0),
      .out_valid (out_valid),
      .res_raddr (res_raddr),
      .res_rdata (res_rdata)
   );

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/mac_pkg.sv
logic/mac_ctrl.sv
logic/mac_operand_mem.sv
logic/mac_muladd.sv
logic/mac_result_mem.sv
logic/mac_top.sv
bench/mac_tb.sv
